/* src/mandel_defines.svh */
/*
 * Mandelbrot renderer parameters
 * Frame size, number format, iteration limit and cluster sizing
 */

`ifndef MANDEL_DEFINES_SVH
`define MANDEL_DEFINES_SVH

// Frame geometry, shrunk for short runs
`define MANDEL_H_DISPLAY    16
`define MANDEL_V_DISPLAY    8

// Q4.12 fixed point
`define MANDEL_FRAC_BITS    12
`define MANDEL_MAX_ITER     31
`define MANDEL_THRESHOLD    (4 << `MANDEL_FRAC_BITS)   // |z|^2 bound, no sqrt

// Cluster and buffering
`define MANDEL_NUM_ENGINES  2
`define MANDEL_FIFO_DEPTH   4           // Also the credit count per frame

// Avalon write master widths
`define MANDEL_AVN_AW       19
`define MANDEL_AVN_DW       16

`endif

/* src/mandel_num_pkg.sv */
/*
 * Mandelbrot number types
 * Fixed-point coordinates, iteration counts, pixel addresses and the view
 */

`include "mandel_defines.svh"

package mandel_num_pkg;

    // ******************************
    // Types
    // ******************************
    typedef logic signed [15:0] fix_t;                              // Q4.12
    typedef logic [$clog2(`MANDEL_MAX_ITER + 1)-1:0] iter_t;        // 5 bits for 31
    typedef logic [`MANDEL_AVN_AW-1:0] addr_t;                      // x + y*H_DISPLAY

    // ******************************
    // Fixed view of the plane
    // ******************************
    // Real axis spans 3.0 over the line
    localparam fix_t DELTA_X = fix_t'((3 << `MANDEL_FRAC_BITS) / `MANDEL_H_DISPLAY);
    // Imaginary axis spans 2.0 over the frame
    localparam fix_t DELTA_Y = fix_t'((2 << `MANDEL_FRAC_BITS) / `MANDEL_V_DISPLAY);
    localparam fix_t START_X = fix_t'(-(2 << `MANDEL_FRAC_BITS));   // -2.0
    localparam fix_t START_Y = fix_t'(-(1 << `MANDEL_FRAC_BITS));   // -1.0

endpackage

/* src/mandel_ctrl_pkg.sv */
/*
 * Mandelbrot control encodings
 * State enums of the scanner, escape engine and VRAM writer
 */

package mandel_ctrl_pkg;

    // Frame walk
    typedef enum logic [1:0] {
        IDLE,       // Waiting for the first start
        SCAN,       // Issuing pixels
        DRAIN,      // All issued, words still outstanding
        DONE        // Every credit back
    } scan_state_e;

    // One escape-time engine
    typedef enum logic [1:0] {
        FREE,       // Ready for a job
        ITERATE,    // z = z*z + c once per clock
        REPORT      // Result on the port for one cycle
    } eng_state_e;

    // Avalon side of the writer
    typedef enum logic {
        EMPTY_WAIT, // Nothing presented
        WRITING     // Word on the bus until accepted
    } wr_state_e;

endpackage

/* src/mandel_job_if.sv */
/*
 * Pixel job channel
 * Carries one point c and its address from the scanner to one engine
 */

`timescale 1ns/1ps

interface mandel_job_if import mandel_num_pkg::*; ();

    logic  job_valid;       // One-cycle dispatch strobe
    fix_t  job_cr;          // Real part of c
    fix_t  job_ci;          // Imaginary part of c
    addr_t job_addr;        // Pixel address in VRAM
    logic  engine_busy;     // From job accept until result shown

    // Scanner side
    modport scanner (
        output job_valid,
        output job_cr,
        output job_ci,
        output job_addr,
        input  engine_busy
    );

    // Engine side
    modport engine (
        input  job_valid,
        input  job_cr,
        input  job_ci,
        input  job_addr,
        output engine_busy
    );

endinterface

/* src/pixel_scanner.sv */
/*
 * Pixel scanner
 * Walks the frame, steps c by the view deltas and hands each pixel
 * to the lowest idle engine while a FIFO credit is held
 */

`timescale 1ns/1ps
`include "mandel_defines.svh"

module pixel_scanner import mandel_num_pkg::*, mandel_ctrl_pkg::*; (
    input  logic          clk,
    input  logic          arst_n,
    input  logic          start,
    input  logic          credit_return,
    mandel_job_if.scanner jobs [`MANDEL_NUM_ENGINES],
    output logic          frame_dispatched
);

    localparam int N  = `MANDEL_NUM_ENGINES;
    localparam int XW = $clog2(`MANDEL_H_DISPLAY);
    localparam int YW = $clog2(`MANDEL_V_DISPLAY);
    localparam int CW = $clog2(`MANDEL_FIFO_DEPTH + 1);
    localparam logic [CW-1:0] FULL_CRED = CW'(`MANDEL_FIFO_DEPTH);

    scan_state_e   state;
    logic [XW-1:0] x_cnt;
    logic [YW-1:0] y_cnt;
    fix_t          cr;              // Running real coordinate
    fix_t          ci;              // Running imaginary coordinate
    addr_t         addr;            // Running pixel address
    logic [CW-1:0] credits;         // Free FIFO slots not yet spent
    logic [N-1:0]  busy;
    logic [N-1:0]  free;
    logic [N-1:0]  grant;
    logic          dispatch;
    logic          last_x;
    logic          last_y;
    logic          drained;
    logic          frame_go;

    // ******************************
    // Job fan-out
    // ******************************
    for (genvar g = 0; g < N; g++) begin : g_jobs
        assign busy[g]           = jobs[g].engine_busy;
        assign jobs[g].job_valid = grant[g];       // Only the granted engine sees it
        assign jobs[g].job_cr    = cr;
        assign jobs[g].job_ci    = ci;
        assign jobs[g].job_addr  = addr;
    end

    assign free     = ~busy;
    assign dispatch = (state == SCAN) && (credits != '0) && (|free);
    assign grant    = dispatch ? (free & (~free + 1'b1)) : '0;   // Lowest set bit
    assign last_x   = (x_cnt == XW'(`MANDEL_H_DISPLAY - 1));
    assign last_y   = (y_cnt == YW'(`MANDEL_V_DISPLAY - 1));
    assign drained  = (state == DRAIN) && (credits == FULL_CRED);   // Last word taken
    assign frame_go = start && (state == IDLE || state == DONE || drained);

    assign frame_dispatched = (state == DRAIN) || (state == DONE);

    // ******************************
    // Frame walk and credits
    // ******************************
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= IDLE;
            x_cnt   <= '0;
            y_cnt   <= '0;
            cr      <= START_X;
            ci      <= START_Y;
            addr    <= '0;
            credits <= '0;
        end else if (frame_go) begin
            state   <= SCAN;            // Fresh frame from the top-left corner
            x_cnt   <= '0;
            y_cnt   <= '0;
            cr      <= START_X;
            ci      <= START_Y;
            addr    <= '0;
            credits <= FULL_CRED;
        end else begin
            credits <= credits - CW'(dispatch) + CW'(credit_return);
            if (dispatch) begin
                addr <= addr + 1'b1;    // Row-major, so the address just counts
                if (last_x) begin
                    x_cnt <= '0;
                    cr    <= START_X;
                    y_cnt <= y_cnt + 1'b1;
                    ci    <= ci + DELTA_Y;
                    if (last_y) begin
                        state <= DRAIN;
                    end
                end else begin
                    x_cnt <= x_cnt + 1'b1;
                    cr    <= cr + DELTA_X;
                end
            end
            // All words written once every credit has come home
            if (drained) begin
                state <= DONE;
            end
        end
    end

endmodule

/* src/escape_engine.sv */
/*
 * Escape-time engine
 * Iterates z = z*z + c one step per clock until |z|^2 passes the
 * threshold or the limit is hit, then reports the count for one cycle
 */

`timescale 1ns/1ps
`include "mandel_defines.svh"

module escape_engine import mandel_num_pkg::*, mandel_ctrl_pkg::*; (
    input  logic         clk,
    input  logic         arst_n,
    mandel_job_if.engine job,
    output logic         res_valid,
    output addr_t        res_addr,
    output iter_t        res_iter
);

    localparam int                 FRAC     = `MANDEL_FRAC_BITS;
    localparam logic signed [31:0] THRESH   = `MANDEL_THRESHOLD;
    localparam iter_t              MAX_ITER = iter_t'(`MANDEL_MAX_ITER);

    eng_state_e state;

    // Working point, loaded per job
    fix_t  zr;
    fix_t  zi;
    fix_t  cr;
    fix_t  ci;
    addr_t addr;
    iter_t count;

    // ******************************
    // One iteration, combinational
    // ******************************
    logic signed [31:0] p_rr;   // zr*zr, Q8.24
    logic signed [31:0] p_ii;   // zi*zi, Q8.24
    logic signed [31:0] p_ri;   // zr*zi, Q8.24
    logic signed [31:0] s_rr;
    logic signed [31:0] s_ii;
    logic signed [31:0] s_ri;
    logic signed [31:0] mag;    // |z|^2 kept wide, never wraps
    logic               escape;

    assign p_rr = zr * zr;
    assign p_ii = zi * zi;
    assign p_ri = zr * zi;

    // Back to Q.12 with the sign kept
    assign s_rr = p_rr >>> FRAC;
    assign s_ii = p_ii >>> FRAC;
    assign s_ri = p_ri >>> (FRAC - 1);     // Doubling folded into the shift

    assign mag    = s_rr + s_ii;
    assign escape = (count == MAX_ITER) || (mag > THRESH);

    // ******************************
    // Control
    // ******************************
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= FREE;
        end else begin
            case (state)
                FREE:    if (job.job_valid) state <= ITERATE;
                ITERATE: if (escape) state <= REPORT;     // Stop test on current z
                REPORT:  state <= FREE;
                default: state <= FREE;
            endcase
        end
    end

    // Point registers
    always_ff @(posedge clk) begin
        if (state == FREE && job.job_valid) begin
            zr    <= '0;                // z starts at the origin
            zi    <= '0;
            cr    <= job.job_cr;
            ci    <= job.job_ci;
            addr  <= job.job_addr;
            count <= '0;
        end else if (state == ITERATE && !escape) begin
            zr    <= fix_t'(s_rr - s_ii + cr);   // Wraps to 16 bits
            zi    <= fix_t'(s_ri + ci);
            count <= count + 1'b1;
        end
    end

    // Busy from the cycle after job_valid through REPORT
    assign job.engine_busy = (state != FREE);

    assign res_valid = (state == REPORT);
    assign res_addr  = addr;
    assign res_iter  = count;

endmodule

/* src/vram_writer.sv */
/*
 * VRAM writer
 * Stages engine results, merges them into a circular FIFO and drives
 * the Avalon-MM write master, returning one credit per accepted word
 */

`timescale 1ns/1ps
`include "mandel_defines.svh"

module vram_writer import mandel_num_pkg::*, mandel_ctrl_pkg::*; (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic [`MANDEL_NUM_ENGINES-1:0] res_valid,
    input  addr_t                         res_addr [`MANDEL_NUM_ENGINES],
    input  iter_t                         res_iter [`MANDEL_NUM_ENGINES],
    input  logic                          frame_dispatched,
    output logic                          credit_return,
    output logic                          done,
    output logic [`MANDEL_AVN_AW-1:0]     avn_address,
    output logic                          avn_write,
    output logic [`MANDEL_AVN_DW-1:0]     avn_writedata,
    input  logic                          avn_waitrequest
);

    localparam int N     = `MANDEL_NUM_ENGINES;
    localparam int DEPTH = `MANDEL_FIFO_DEPTH;
    localparam int PW    = $clog2(DEPTH);
    localparam int CW    = $clog2(DEPTH + 1);
    localparam int DW    = `MANDEL_AVN_DW;
    localparam int TOTAL = `MANDEL_H_DISPLAY * `MANDEL_V_DISPLAY;
    localparam int WW    = $clog2(TOTAL + 1);

    logic [N-1:0]  stg_valid;
    logic [N-1:0]  pick;
    addr_t         stg_addr [N];
    iter_t         stg_iter [N];
    addr_t         push_addr;
    iter_t         push_iter;
    logic          push;
    addr_t         fifo_addr [DEPTH];
    iter_t         fifo_iter [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] fifo_cnt;
    logic          pop;
    logic          accept;
    wr_state_e     wr_state;
    logic [WW-1:0] words;           // Accepted in this frame

    // ******************************
    // Staging and merge
    // ******************************
    assign pick = stg_valid & (~stg_valid + 1'b1);   // Lowest engine index wins
    assign push = |stg_valid;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stg_valid <= '0;
        end else begin
            stg_valid <= (stg_valid & ~pick) | res_valid;  // New pulse always lands
        end
    end

    always_ff @(posedge clk) begin
        for (int e = 0; e < N; e++) begin
            if (res_valid[e]) begin
                stg_addr[e] <= res_addr[e];
                stg_iter[e] <= res_iter[e];
            end
        end
    end

    always_comb begin
        push_addr = '0;
        push_iter = '0;
        for (int e = 0; e < N; e++) begin
            if (pick[e]) begin
                push_addr = stg_addr[e];
                push_iter = stg_iter[e];
            end
        end
    end

    // ******************************
    // Result FIFO
    // ******************************
    // Credits bound the fill, so a push never finds it full
    always_ff @(posedge clk) begin
        if (push) begin
            fifo_addr[wr_ptr] <= push_addr;
            fifo_iter[wr_ptr] <= push_iter;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fifo_cnt <= '0;
        end else begin
            wr_ptr   <= wr_ptr + PW'(push);       // Power-of-two depth wraps itself
            rd_ptr   <= rd_ptr + PW'(pop);
            fifo_cnt <= fifo_cnt + CW'(push) - CW'(pop);
        end
    end

    // ******************************
    // Avalon write master
    // ******************************
    assign accept        = (wr_state == WRITING) && !avn_waitrequest;
    assign pop           = (fifo_cnt != '0) && (wr_state == EMPTY_WAIT || accept);
    assign avn_write     = (wr_state == WRITING);
    assign credit_return = accept;                 // One slot freed per word

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_state <= EMPTY_WAIT;
        end else if (pop) begin
            wr_state <= WRITING;        // Back-to-back when more is queued
        end else if (accept) begin
            wr_state <= EMPTY_WAIT;
        end
    end

    // Held through waitrequest, only reloaded on pop
    always_ff @(posedge clk) begin
        if (pop) begin
            avn_address   <= fifo_addr[rd_ptr];
            avn_writedata <= DW'(fifo_iter[rd_ptr]);   // Zero-extended count
        end
    end

    // Frame completion, cleared once the scanner starts over
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            words <= '0;
            done  <= 1'b0;
        end else if (done && !frame_dispatched) begin
            words <= '0;
            done  <= 1'b0;
        end else begin
            words <= words + WW'(accept);
            if (frame_dispatched && accept && words == WW'(TOTAL - 1)) begin
                done <= 1'b1;           // Cycle after the last word
            end
        end
    end

endmodule

/* src/mandel_core.sv */
/*
 * Mandelbrot renderer core
 * Scanner, escape-engine cluster and VRAM writer behind an
 * Avalon-MM write master
 */

`timescale 1ns/1ps
`include "mandel_defines.svh"

module mandel_core import mandel_num_pkg::*; (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      start,            // One-cycle pulse
    output logic                      done,             // Level until next start
    output logic [`MANDEL_AVN_AW-1:0] avn_address,
    output logic                      avn_write,
    output logic [`MANDEL_AVN_DW-1:0] avn_writedata,
    input  logic                      avn_waitrequest
);

    localparam int N = `MANDEL_NUM_ENGINES;

    // Engine results
    logic [N-1:0] res_valid;
    addr_t        res_addr [N];
    iter_t        res_iter [N];

    // Credit loop and frame status
    logic         credit_return;
    logic         frame_dispatched;

    // One job channel per engine
    mandel_job_if job_if [N] ();

    // ******************************
    // Scanner
    // ******************************
    pixel_scanner u_scanner (
        .clk              (clk),
        .arst_n           (arst_n),
        .start            (start),
        .credit_return    (credit_return),
        .jobs             (job_if),
        .frame_dispatched (frame_dispatched)
    );

    // ******************************
    // Engine cluster
    // ******************************
    for (genvar g = 0; g < N; g++) begin : g_engine
        escape_engine u_engine (
            .clk       (clk),
            .arst_n    (arst_n),
            .job       (job_if[g]),
            .res_valid (res_valid[g]),
            .res_addr  (res_addr[g]),
            .res_iter  (res_iter[g])
        );
    end

    // ******************************
    // Writer
    // ******************************
    vram_writer u_writer (
        .clk              (clk),
        .arst_n           (arst_n),
        .res_valid        (res_valid),
        .res_addr         (res_addr),
        .res_iter         (res_iter),
        .frame_dispatched (frame_dispatched),
        .credit_return    (credit_return),
        .done             (done),
        .avn_address      (avn_address),
        .avn_write        (avn_write),
        .avn_writedata    (avn_writedata),
        .avn_waitrequest  (avn_waitrequest)
    );

endmodule

/* test/mandel_checker.sv */
/*
 * Mandelbrot write checker
 * Watches the Avalon write master, models the escape rule per pixel,
 * tracks coverage of every address and counts the errors
 */

`timescale 1ns/1ps
`include "mandel_defines.svh"

module mandel_checker import mandel_num_pkg::*; (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      start,
    input  logic                      done,
    input  logic [`MANDEL_AVN_AW-1:0] avn_address,
    input  logic                      avn_write,
    input  logic [`MANDEL_AVN_DW-1:0] avn_writedata,
    input  logic                      avn_waitrequest,
    input  logic                      frame_compare,    // Also match the first frame
    output int                        value_errs,
    output int                        pixel_errs
);

    localparam int H     = `MANDEL_H_DISPLAY;
    localparam int TOTAL = `MANDEL_H_DISPLAY * `MANDEL_V_DISPLAY;
    localparam int DW    = `MANDEL_AVN_DW;

    logic          written [TOTAL];         // Seen in this frame
    logic [DW-1:0] first_frame [TOTAL];     // Frame 0 image
    logic [DW-1:0] this_frame [TOTAL];
    int            val_cnt = 0;
    int            pix_cnt = 0;
    int            accepted;
    int            frames;
    logic          started;                 // A start was seen since reset
    logic          done_q;
    logic          accept_q;                // Word taken at the previous edge
    logic          stall_q;                 // Word held by waitrequest
    logic [`MANDEL_AVN_AW-1:0] addr_q;
    logic [DW-1:0]             data_q;

    assign value_errs = val_cnt;
    assign pixel_errs = pix_cnt;

    // ******************************
    // Reference model
    // ******************************
    // Iterations of z = z*z + c before |z|^2 passes 4.0, capped at the limit
    function automatic int escape_count(input fix_t cr, input fix_t ci);
        fix_t   zr;
        fix_t   zi;
        longint rr;
        longint ii;
        longint ri;
        int     n;
        zr = '0;
        zi = '0;
        for (n = 0; n < `MANDEL_MAX_ITER; n++) begin
            rr = (longint'(zr) * longint'(zr)) >>> `MANDEL_FRAC_BITS;
            ii = (longint'(zi) * longint'(zi)) >>> `MANDEL_FRAC_BITS;
            if (rr + ii > longint'(`MANDEL_THRESHOLD)) break;
            ri = (2 * longint'(zr) * longint'(zi)) >>> `MANDEL_FRAC_BITS;
            zr = fix_t'(rr - ii + longint'(cr));    // Keep the low 16 bits
            zi = fix_t'(ri + longint'(ci));
        end
        return n;
    endfunction

    // Point c of a pixel from its address
    function automatic int expected_for_addr(input int a);
        fix_t cr;
        fix_t ci;
        cr = fix_t'(START_X + (a % H) * DELTA_X);
        ci = fix_t'(START_Y + (a / H) * DELTA_Y);
        return escape_count(cr, ci);
    endfunction

    // ******************************
    // Per-word and per-frame checks
    // ******************************
    task automatic check_word();
        int            a;
        logic [DW-1:0] exp_data;
        a = int'(avn_address);
        if (!started) begin
            $display("Word accepted at address %0d with no frame running", a);
            pix_cnt++;
        end else if (a >= TOTAL) begin
            $display("Word accepted at address %0d, outside the frame", a);
            pix_cnt++;
        end else begin
            if (written[a]) begin
                $display("Pixel %0d written twice in frame %0d", a, frames);
                pix_cnt++;
            end
            written[a] = 1'b1;
            accepted++;
            exp_data = DW'(expected_for_addr(a));
            if (avn_writedata !== exp_data) begin
                $display("FAILED avn_writedata at 0x%h: expected 0x%h, got 0x%h",
                         avn_address, exp_data, avn_writedata);
                val_cnt++;
            end
            this_frame[a] = avn_writedata;
            if (frame_compare && frames > 0 && avn_writedata !== first_frame[a]) begin
                $display("FAILED avn_writedata at 0x%h: expected 0x%h, got 0x%h",
                         avn_address, first_frame[a], avn_writedata);
                val_cnt++;
            end
        end
    endtask

    task automatic close_frame();
        if (accepted != TOTAL || !accept_q) begin
            $display("Done rose after %0d words, not right after word %0d", accepted, TOTAL);
            pix_cnt++;
        end
        for (int i = 0; i < TOTAL; i++) begin
            if (!written[i]) begin
                $display("Pixel %0d never written in frame %0d", i, frames);
                pix_cnt++;
            end
        end
        if (frames == 0) first_frame = this_frame;     // Reference for later frames
        frames++;
    endtask

    // Samples at the edge, so waitrequest and start are a cycle old here
    always @(posedge clk) begin
        if (!arst_n) begin
            started  = 1'b0;
            done_q   = 1'b0;
            accept_q = 1'b0;
            stall_q  = 1'b0;
            accepted = 0;
            frames   = 0;
            foreach (written[i]) written[i] = 1'b0;
        end else begin
            if (!started && (avn_write || done)) begin
                $display("Write or done seen before the first start");
                pix_cnt++;
            end
            if (start) begin
                started  = 1'b1;
                accepted = 0;
                foreach (written[i]) written[i] = 1'b0;
            end
            if (stall_q) begin                          // Held word must not move
                if (avn_write !== 1'b1) begin
                    $display("Write dropped while waitrequest was high");
                    pix_cnt++;
                end
                if (avn_address !== addr_q) begin
                    $display("FAILED avn_address: expected 0x%h, got 0x%h", addr_q, avn_address);
                    val_cnt++;
                end
                if (avn_writedata !== data_q) begin
                    $display("FAILED avn_writedata: expected 0x%h, got 0x%h",
                             data_q, avn_writedata);
                    val_cnt++;
                end
            end
            if (avn_write && !avn_waitrequest) check_word();
            if (done && !done_q) close_frame();
            accept_q = avn_write && !avn_waitrequest;
            stall_q  = avn_write && avn_waitrequest;
            addr_q   = avn_address;
            data_q   = avn_writedata;
            done_q   = done;
        end
    end

endmodule

/* test/mandel_core_tb.sv */
/*
 * Mandelbrot core testbench
 * Runs a table of frames with random waitrequest and waits for done
 */

`timescale 1ns/1ps
`include "mandel_defines.svh"

module mandel_core_tb import mandel_num_pkg::*; ();

    localparam int TIMEOUT = 50000;         // Cycles per wait
    localparam int ROWS    = 4;

    // ******************************
    // Stimulus table
    // ******************************
    localparam int   ROW_PCT     [ROWS] = '{0, 50, 90, 0};   // Waitrequest percentage
    localparam int   ROW_DELAY   [ROWS] = '{6, 3, 9, 1};     // Cycles before start
    localparam logic ROW_COMPARE [ROWS] = '{1'b0, 1'b1, 1'b1, 1'b1};

    logic                      clk;
    logic                      arst_n;
    logic                      start;
    logic                      done;
    addr_t                     avn_address;
    logic                      avn_write;
    logic [`MANDEL_AVN_DW-1:0] avn_writedata;
    logic                      avn_waitrequest;
    int                        wait_pct;
    logic                      frame_compare;
    int                        value_errs;
    int                        pixel_errs;
    int                        timeout_errs;

    mandel_core u_dut (
        .clk             (clk),
        .arst_n          (arst_n),
        .start           (start),
        .done            (done),
        .avn_address     (avn_address),
        .avn_write       (avn_write),
        .avn_writedata   (avn_writedata),
        .avn_waitrequest (avn_waitrequest)
    );

    mandel_checker u_checker (
        .clk             (clk),
        .arst_n          (arst_n),
        .start           (start),
        .done            (done),
        .avn_address     (avn_address),
        .avn_write       (avn_write),
        .avn_writedata   (avn_writedata),
        .avn_waitrequest (avn_waitrequest),
        .frame_compare   (frame_compare),
        .value_errs      (value_errs),
        .pixel_errs      (pixel_errs)
    );

    // 20 ns clock
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // New waitrequest each cycle at the current row's rate
    initial begin
        avn_waitrequest = 1'b0;
        void'($urandom(21));
        forever begin
            @(posedge clk);
            #2;
            avn_waitrequest = (int'($urandom % 100) < wait_pct);
        end
    end

    task automatic pulse_start();
        @(posedge clk);
        #2 start = 1'b1;
        @(posedge clk);
        #2 start = 1'b0;
    endtask

    // Poll done just after each edge until it reaches the level
    task automatic wait_done_level(input logic level, input string what, output logic ok);
        int cycles;
        cycles = 0;
        ok     = 1'b1;
        while (done !== level && ok) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles >= TIMEOUT) begin
                $display("Timeout: done did not %s within %0d cycles", what, TIMEOUT);
                ok = 1'b0;
            end
        end
    endtask

    // ******************************
    // Main sequence
    // ******************************
    initial begin
        logic ok;
        logic timed_out;
        int   total;
        arst_n        = 1'b0;
        start         = 1'b0;
        wait_pct      = 0;
        frame_compare = 1'b0;
        timed_out     = 1'b0;
        timeout_errs  = 0;
        repeat (10) @(posedge clk);
        #2 arst_n = 1'b1;
        for (int r = 0; r < ROWS && !timed_out; r++) begin
            wait_pct      = ROW_PCT[r];
            frame_compare = ROW_COMPARE[r];
            repeat (ROW_DELAY[r]) @(posedge clk);   // Idle window, checker watches it
            pulse_start();
            wait_done_level(1'b0, "fall after start", ok);  // Old frame's done clears
            if (ok) wait_done_level(1'b1, "rise", ok);
            if (!ok) begin
                timed_out = 1'b1;
                timeout_errs++;
            end else begin
                $display("Frame %0d done at %0d%% waitrequest", r, ROW_PCT[r]);
            end
        end
        repeat (4) @(posedge clk);
        total = value_errs + pixel_errs + timeout_errs;
        $display("Errors: value %0d, pixel %0d, timeout %0d",
                 value_errs, pixel_errs, timeout_errs);
        if (total == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* mandel_core.f */
+incdir+src
src/mandel_num_pkg.sv
src/mandel_ctrl_pkg.sv
src/mandel_job_if.sv
src/pixel_scanner.sv
src/escape_engine.sv
src/vram_writer.sv
src/mandel_core.sv
test/mandel_checker.sv
test/mandel_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the Mandelbrot core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
    -f mandel_core.f --top-module mandel_core_tb \
    -Mdir obj_dir -o mandel_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/mandel_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TESTS PASSED$" "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
